// ==== all.f ====
logic/rv_pkg.sv
logic/datapath_controller.sv
logic/alu.sv
logic/register_file.sv
logic/imm_gen.sv
logic/load_store_unit.sv
logic/datapath.sv
logic/rv_core.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv

// ==== dv/rv_core_assert.sv ====
module rv_core_assert
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic [31:0] i_inst_addr,
    input  logic        i_mem_wr_enable,
    input  logic        i_mem_rd_enable,
    input  logic [3:0]  i_mem_byte_enable
);

    // A load and a store are never the same instruction
    assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_mem_wr_enable && i_mem_rd_enable))
        else $error("Read and write enables high in the same cycle");

    assert property (@(posedge i_clock) disable iff (i_reset)
        i_inst_addr[1:0] == 2'b00)  // Only 32-bit instructions
        else $error("Fetch address not word aligned");

    assert property (@(posedge i_clock) disable iff (i_reset)
        !i_mem_wr_enable |-> i_mem_byte_enable == 4'b0000)
        else $error("Byte lanes enabled without a store");

endmodule

// ==== dv/rv_core_tb.sv ====
module rv_core_tb;

    localparam int NUM_PROLOGUE = 64;  // LUI and ADDI for each register
    localparam int NUM_RANDOM   = 2000;
    localparam int MAX_CYCLES   = NUM_PROLOGUE + NUM_RANDOM + 36;  // 2100

    logic        clock;
    logic        reset;
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic [31:0] mem_addr;
    logic        mem_wr_enable;
    logic        mem_rd_enable;
    logic [3:0]  mem_byte_enable;
    logic [31:0] mem_wr_data;
    logic [31:0] mem_rd_data;

    logic [31:0] regs [32];              // Model registers
    logic [31:0] pc;                     // Model PC
    logic [31:0] ref_mem [logic [29:0]]; // Model memory, word addressed
    logic [31:0] dut_mem [logic [29:0]]; // Memory as written by the DUT

    logic        exp_wb;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wb_val;
    logic        exp_store;
    logic        exp_load;
    logic [31:0] exp_addr;
    logic [3:0]  exp_be;
    logic [31:0] exp_wdata;
    logic [31:0] exp_next_pc;

    logic        observe_pending;  // Next instruction stores observe_rd
    logic [4:0]  observe_rd;
    int          pc_errors;
    int          mem_errors;
    int          cycles;

    rv_core u_rv_core (
        .i_clock           (clock),
        .i_reset           (reset),
        .o_inst_addr       (inst_addr),
        .i_inst            (inst),
        .o_mem_addr        (mem_addr),
        .o_mem_wr_enable   (mem_wr_enable),
        .o_mem_rd_enable   (mem_rd_enable),
        .o_mem_byte_enable (mem_byte_enable),
        .o_mem_wr_data     (mem_wr_data),
        .i_mem_rd_data     (mem_rd_data)
    );

    bind rv_core rv_core_assert u_rv_core_assert (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_inst_addr       (o_inst_addr),
        .i_mem_wr_enable   (o_mem_wr_enable),
        .i_mem_rd_enable   (o_mem_rd_enable),
        .i_mem_byte_enable (o_mem_byte_enable)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] lane_mask(logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] data,
                                                logic [3:0] be);
        return (old & ~lane_mask(be)) | (data & lane_mask(be));
    endfunction

    function automatic logic [31:0] ref_word(logic [31:0] addr);
        return ref_mem.exists(addr[31:2]) ? ref_mem[addr[31:2]] : 32'd0;
    endfunction

    // Integer result by funct3, alt picks SUB and SRA
    function automatic logic [31:0] arith(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_decode(input logic [31:0] op);
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] word;
        logic [31:0] lane;
        logic        take;
        f3 = op[14:12];
        a = regs[op[19:15]];
        b = regs[op[24:20]];
        imm_i = {{20{op[31]}}, op[31:20]};
        exp_rd = op[11:7];
        exp_wb = 1'b0;
        exp_store = 1'b0;
        exp_load = 1'b0;
        exp_be = 4'b0000;
        exp_next_pc = pc + 32'd4;  // Also for unknown encodings
        take = 1'b0;
        case (op[6:0])
            7'h37: {exp_wb, exp_wb_val} = {1'b1, op[31:12], 12'b0};
            7'h17: {exp_wb, exp_wb_val} = {1'b1, pc + {op[31:12], 12'b0}};
            7'h6f:
            begin
                {exp_wb, exp_wb_val} = {1'b1, pc + 32'd4};
                exp_next_pc = pc + {{12{op[31]}}, op[19:12], op[20], op[30:21], 1'b0};
            end
            7'h67:
                if (f3 == 3'b000)
                begin
                    {exp_wb, exp_wb_val} = {1'b1, pc + 32'd4};
                    exp_next_pc = (a + imm_i) & ~32'd1;
                end
            7'h63:
            begin
                case (f3)
                    3'b000:  take = a == b;
                    3'b001:  take = a != b;
                    3'b100:  take = $signed(a) < $signed(b);
                    3'b101:  take = $signed(a) >= $signed(b);  // Equal is taken
                    3'b110:  take = a < b;
                    3'b111:  take = a >= b;
                    default: take = 1'b0;
                endcase
                if (take)
                    exp_next_pc = pc + {{20{op[31]}}, op[7], op[30:25], op[11:8], 1'b0};
            end
            7'h03:
                if (f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111)
                begin
                    exp_load = 1'b1;
                    exp_wb = 1'b1;
                    exp_addr = a + imm_i;
                    word = ref_word(exp_addr);
                    lane = (f3[1:0] == 2'b00) ? word >> {exp_addr[1:0], 3'b000}
                                              : word >> {exp_addr[1], 4'b0000};
                    case (f3[1:0])
                        2'b00:   exp_wb_val = {{24{lane[7] & ~f3[2]}}, lane[7:0]};
                        2'b01:   exp_wb_val = {{16{lane[15] & ~f3[2]}}, lane[15:0]};
                        default: exp_wb_val = word;
                    endcase
                end
            7'h23:
                if (f3 <= 3'b010)
                begin
                    exp_store = 1'b1;
                    exp_addr = a + {{20{op[31]}}, op[31:25], op[11:7]};
                    exp_be = 4'b1111;
                    exp_wdata = b;
                    if (f3 == 3'b000)
                        {exp_be, exp_wdata} = {4'b0001 << exp_addr[1:0],
                                               b << {exp_addr[1:0], 3'b000}};
                    else if (f3 == 3'b001)
                        {exp_be, exp_wdata} = {exp_addr[1] ? 4'b1100 : 4'b0011,
                                               b << {exp_addr[1], 4'b0000}};
                end
            7'h13:
                if (f3 != 3'b001 && f3 != 3'b101)  // Shift-immediates are not decoded
                    {exp_wb, exp_wb_val} = {1'b1, arith(f3, 1'b0, a, imm_i)};
            7'h33:
                if (op[31:25] == 7'd0 || (op[31:25] == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)))
                    {exp_wb, exp_wb_val} = {1'b1, arith(f3, op[30], a, b)};
            default: ;
        endcase
    endtask

    function automatic logic [31:0] random_instruction();
        logic [31:0] r;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        r = $urandom;
        f3 = r[14:12];
        case ($urandom % 16)
            0, 1, 2:
            begin
                if (f3 == 3'b001 || f3 == 3'b101)
                    f3 = f3 + 3'd1;
                return {r[31:15], f3, r[11:7], 7'h13};
            end
            3, 4, 5: return {1'b0, r[30] & (f3 == 3'b000 || f3 == 3'b101), 5'd0, r[24:7], 7'h33};
            6:       return {r[31:7], 7'h37};
            7:       return {r[31:7], 7'h17};
            8:       return {r[31:22], 1'b0, r[20:7], 7'h6f};  // Offset bit 1 clear
            9:       return {r[31:22], 1'b0, r[20], 8'd0, r[11:7], 7'h67};  // JALR off(x0)
            10, 11:
            begin
                if (f3 == 3'b010 || f3 == 3'b011)
                    f3 = f3 + 3'd2;
                rs2 = r[2] ? r[19:15] : r[24:20];  // Equal operands now and then
                return {r[31:25], rs2, r[19:15], f3, r[11:9], 1'b0, r[7], 7'h63};
            end
            12, 13:
            begin
                if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111)
                    f3 = 3'b010;
                return {6'd0, r[5:0], 5'd0, f3, r[11:7], 7'h03};  // Offsets 0 to 63
            end
            14:      return {6'd0, r[5], r[24:20], 5'd0, 3'(r[13:12] % 3), r[4:0], 7'h23};
            default:
                case (r[2:0])
                    3'd0:    return {r[31:7], 7'h73};                     // SYSTEM
                    3'd1:    return {r[31:15], r[14], 2'b01, r[11:7], 7'h13};  // Shift-imm
                    3'd2:    return {7'b0000001, r[24:7], 7'h33};         // Multiply
                    3'd3:    return {r[31:15], 3'b011, r[11:7], 7'h23};
                    default: return {r[31:15], 3'b010, r[11:7], 7'h63};
                endcase
        endcase
    endfunction

    initial
    begin
        logic [31:0] r;
        void'($urandom(8));
        reset = 1'b1;
        inst = 32'h0000_2023;  // SW x0, 0(x0), must stay off the bus in reset
        mem_rd_data = 32'd0;
        pc = 32'd0;
        observe_pending = 1'b0;
        pc_errors = 0;
        mem_errors = 0;
        foreach (regs[i])
            regs[i] = 32'd0;
        repeat (15) @(posedge clock);
        #28;
        if (mem_wr_enable !== 1'b0 || mem_byte_enable !== 4'h0)
        begin
            mem_errors++;
            $display("FAIL o_mem_wr_enable/o_mem_byte_enable in reset: got %h/%h expected 0/0",
                     mem_wr_enable, mem_byte_enable);
        end
        @(posedge clock);
        #2;
        reset = 1'b0;
        for (int step = 0; step < NUM_PROLOGUE + NUM_RANDOM; step++)
        begin
            r = $urandom;
            if (step < NUM_PROLOGUE && step % 2 == 0)
                inst = {r[31:12], 5'(step / 2), 7'h37};
            else if (step < NUM_PROLOGUE)
                inst = {r[31:20], 5'(step / 2), 3'b000, 5'(step / 2), 7'h13};
            else if (observe_pending)
                inst = {6'd0, r[5], observe_rd, 5'd0, 3'b010, r[4:2], 2'b00, 7'h23};  // SW rd
            else
                inst = random_instruction();
            observe_pending = 1'b0;
            #1;
            mem_rd_data = dut_mem.exists(mem_addr[31:2]) ? dut_mem[mem_addr[31:2]] : 32'd0;
            #25;
            model_decode(inst);
            if (inst_addr !== pc)
            begin
                pc_errors++;
                $display("FAIL o_inst_addr: got %h expected %h", inst_addr, pc);
            end
            if (mem_wr_enable !== exp_store || mem_rd_enable !== exp_load)
            begin
                mem_errors++;
                $display("FAIL o_mem_wr_enable/o_mem_rd_enable: got %h/%h expected %h/%h",
                         mem_wr_enable, mem_rd_enable, exp_store, exp_load);
            end
            if ((exp_store || exp_load) && mem_addr !== exp_addr)
            begin
                mem_errors++;
                $display("FAIL o_mem_addr: got %h expected %h", mem_addr, exp_addr);
            end
            if (mem_byte_enable !== exp_be)
            begin
                mem_errors++;
                $display("FAIL o_mem_byte_enable: got %h expected %h", mem_byte_enable, exp_be);
            end
            if (exp_store && (mem_wr_data & lane_mask(exp_be)) !== (exp_wdata & lane_mask(exp_be)))
            begin
                mem_errors++;
                $display("FAIL o_mem_wr_data: got %h expected %h",
                         mem_wr_data & lane_mask(exp_be), exp_wdata & lane_mask(exp_be));
            end
            if (mem_wr_enable)  // Memory commits at the coming edge
                dut_mem[mem_addr[31:2]] = merge_lanes(dut_mem.exists(mem_addr[31:2]) ?
                    dut_mem[mem_addr[31:2]] : 32'd0, mem_wr_data, mem_byte_enable);
            if (exp_wb && exp_rd != 5'd0)
                regs[exp_rd] = exp_wb_val;
            if (exp_store)
                ref_mem[exp_addr[31:2]] = merge_lanes(ref_word(exp_addr), exp_wdata, exp_be);
            pc = exp_next_pc;
            if (step >= NUM_PROLOGUE && exp_wb)
                {observe_pending, observe_rd} = {1'b1, exp_rd};  // x0 included
            @(posedge clock);
            #2;
        end
        $display("Errors: %0d on the fetch address, %0d on the data port", pc_errors, mem_errors);
        if (pc_errors + mem_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clock);
            if (!reset)
                cycles++;
        end
        $display("Timeout: the instruction stream did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== logic/alu.sv ====
module alu
    import rv_pkg::*;
(
    input  AluOp i_op,      // Operation select
    input  Word  i_a,       // Operand A
    input  Word  i_b,       // Operand B
    output Word  o_result   // Result
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];  // Shift amount

    always_comb
    begin
        case (i_op)
            AluOp_SUB:  o_result = i_a - i_b;
            AluOp_SLL:  o_result = i_a << shamt;
            AluOp_SLT:  o_result = {31'b0, $signed(i_a) < $signed(i_b)};
            AluOp_SLTU: o_result = {31'b0, i_a < i_b};
            AluOp_XOR:  o_result = i_a ^ i_b;
            AluOp_SRL:  o_result = i_a >> shamt;
            AluOp_SRA:  o_result = Word'($signed(i_a) >>> shamt);
            AluOp_OR:   o_result = i_a | i_b;
            AluOp_AND:  o_result = i_a & i_b;
            default:    o_result = i_a + i_b;  // ADD and Unknown
        endcase
    end

endmodule

// ==== logic/datapath.sv ====
module datapath
    import rv_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  Inst         i_inst,              // Current instruction
    input  logic        i_mem_wr_enable,     // Store, already gated by reset
    input  DataAccess   i_mem_access,
    input  logic        i_mem_unsigned,
    input  PcNextSel    i_pc_next_sel,
    input  AluOp        i_alu_control,
    input  OperandASel  i_operand_a_sel,
    input  OperandBSel  i_operand_b_sel,
    input  logic        i_reg_wr_enable,
    input  RegWrDataSel i_reg_wr_data_sel,
    input  Word         i_mem_rd_data,
    output Word         o_pc,                // Fetch address
    output logic        o_isEqual,
    output logic        o_isLessSigned,
    output logic        o_isLessUnsigned,
    output Word         o_mem_addr,
    output Word         o_mem_wr_data,
    output logic [3:0]  o_byte_enable
);

    Word pc;
    Word pc_plus4;
    Word rs1_data;
    Word rs2_data;
    Word imm;
    Word operand_a;
    Word operand_b;
    Word alu_result;
    Word load_data;
    Word wr_data;
    Word pc_next;

    register_file u_register_file (
        .i_clock     (i_clock),
        .i_rs1       (i_inst[19:15]),
        .i_rs2       (i_inst[24:20]),
        .i_rd        (i_inst[11:7]),
        .i_wr_enable (i_reg_wr_enable & ~i_reset),  // No writes in reset
        .i_wr_data   (wr_data),
        .o_rs1_data  (rs1_data),
        .o_rs2_data  (rs2_data)
    );

    imm_gen u_imm_gen (.i_inst(i_inst), .o_imm(imm));

    assign o_isEqual        = rs1_data == rs2_data;
    assign o_isLessSigned   = $signed(rs1_data) < $signed(rs2_data);
    assign o_isLessUnsigned = rs1_data < rs2_data;

    always_comb
    begin
        case (i_operand_a_sel)
            OpASel_Pc:   operand_a = pc;
            OpASel_Zero: operand_a = 32'd0;
            default:     operand_a = rs1_data;
        endcase
        case (i_operand_b_sel)
            OpBSel_Imm:  operand_b = imm;
            OpBSel_Four: operand_b = 32'd4;
            default:     operand_b = rs2_data;
        endcase
    end

    alu u_alu (.i_op(i_alu_control), .i_a(operand_a), .i_b(operand_b), .o_result(alu_result));

    assign o_mem_addr = alu_result;  // Loads and stores add rs1 + imm

    load_store_unit u_load_store_unit (
        .i_addr        (alu_result),
        .i_access      (i_mem_access),
        .i_unsigned    (i_mem_unsigned),
        .i_wr_enable   (i_mem_wr_enable),
        .i_store_data  (rs2_data),
        .i_mem_rd_data (i_mem_rd_data),
        .o_byte_enable (o_byte_enable),
        .o_mem_wr_data (o_mem_wr_data),
        .o_load_data   (load_data)
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        case (i_reg_wr_data_sel)
            WrSel_Mem: wr_data = load_data;
            WrSel_Pc4: wr_data = pc_plus4;
            default:   wr_data = alu_result;
        endcase
        case (i_pc_next_sel)
            PcSel_Offset:   pc_next = pc + imm;
            PcSel_Indirect: pc_next = (rs1_data + imm) & ~32'd1;  // JALR clears bit 0
            default:        pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    assign o_pc = pc;

endmodule

// ==== logic/datapath_controller.sv ====
module datapath_controller
    import rv_pkg::*;
(
    input  Inst         i_inst,            // Current instruction
    input  logic        i_isEqual,         // rs1 == rs2
    input  logic        i_isLessSigned,    // rs1 < rs2 signed
    input  logic        i_isLessUnsigned,  // rs1 < rs2 unsigned

    output logic        o_memWrEnable,     // Store this cycle
    output logic        o_memRdEnable,     // Load this cycle
    output DataAccess   o_memAccess,       // Access size
    output logic        o_memUnsigned,     // Zero-extend load data
    output PcNextSel    o_pcNextSel,       // Next PC source

    output AluOp        o_aluControl,      // ALU operation
    output OperandASel  o_operandASel,     // ALU operand A source
    output OperandBSel  o_operandBSel,     // ALU operand B source

    output logic        o_regWrEnable,     // Register write
    output RegWrDataSel o_regWrDataSel     // Write-back source
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic [6:0] opcode;

    assign funct7 = i_inst[31:25];
    assign funct3 = i_inst[14:12];
    assign opcode = i_inst[6:0];

    always_comb
    begin
        // Anything not matched below behaves as a no-op
        o_aluControl   = AluOp_Unknown;
        o_operandASel  = OpASel_Reg;
        o_operandBSel  = OpBSel_Reg;
        o_pcNextSel    = PcSel_Plus4;
        o_memWrEnable  = 1'b0;
        o_memRdEnable  = 1'b0;
        o_memAccess    = DataAccess_Word;
        o_memUnsigned  = 1'b0;
        o_regWrEnable  = 1'b0;
        o_regWrDataSel = WrSel_Alu;

        casez ({funct7, funct3, opcode})
            {7'b???????, 3'b???, OpCode_LUI}:
            begin
                o_aluControl  = AluOp_ADD;  // 0 + imm
                o_operandASel = OpASel_Zero;
                o_operandBSel = OpBSel_Imm;
                o_regWrEnable = 1'b1;
            end
            {7'b???????, 3'b???, OpCode_AUIPC}:
            begin
                o_aluControl  = AluOp_ADD;  // PC + imm
                o_operandASel = OpASel_Pc;
                o_operandBSel = OpBSel_Imm;
                o_regWrEnable = 1'b1;
            end
            {7'b???????, 3'b???, OpCode_JAL}:
            begin
                o_pcNextSel    = PcSel_Offset;
                o_regWrEnable  = 1'b1;
                o_regWrDataSel = WrSel_Pc4;
            end
            {7'b???????, 3'b000, OpCode_JALR}:
            begin
                o_pcNextSel    = PcSel_Indirect;
                o_regWrEnable  = 1'b1;
                o_regWrDataSel = WrSel_Pc4;
            end
            {7'b???????, 3'b000, OpCode_Branch}:  // BEQ
                if (i_isEqual)
                    o_pcNextSel = PcSel_Offset;
            {7'b???????, 3'b001, OpCode_Branch}:  // BNE
                if (!i_isEqual)
                    o_pcNextSel = PcSel_Offset;
            {7'b???????, 3'b100, OpCode_Branch}:  // BLT
                if (i_isLessSigned)
                    o_pcNextSel = PcSel_Offset;
            {7'b???????, 3'b101, OpCode_Branch}:  // BGE, equal included
                if (!i_isLessSigned)
                    o_pcNextSel = PcSel_Offset;
            {7'b???????, 3'b110, OpCode_Branch}:  // BLTU
                if (i_isLessUnsigned)
                    o_pcNextSel = PcSel_Offset;
            {7'b???????, 3'b111, OpCode_Branch}:  // BGEU, equal included
                if (!i_isLessUnsigned)
                    o_pcNextSel = PcSel_Offset;
            {7'b???????, 3'b000, OpCode_Load},    // LB
            {7'b???????, 3'b001, OpCode_Load},    // LH
            {7'b???????, 3'b010, OpCode_Load},    // LW
            {7'b???????, 3'b100, OpCode_Load},    // LBU
            {7'b???????, 3'b101, OpCode_Load}:    // LHU
            begin
                o_aluControl   = AluOp_ADD;       // Address rs1 + imm
                o_operandBSel  = OpBSel_Imm;
                o_memRdEnable  = 1'b1;
                o_memUnsigned  = funct3[2];
                o_regWrEnable  = 1'b1;
                o_regWrDataSel = WrSel_Mem;
                if (funct3[1:0] == 2'b00)
                    o_memAccess = DataAccess_Byte;
                else if (funct3[1:0] == 2'b01)
                    o_memAccess = DataAccess_Half;
            end
            {7'b???????, 3'b000, OpCode_Store},   // SB
            {7'b???????, 3'b001, OpCode_Store},   // SH
            {7'b???????, 3'b010, OpCode_Store}:   // SW
            begin
                o_aluControl  = AluOp_ADD;
                o_operandBSel = OpBSel_Imm;
                o_memWrEnable = 1'b1;
                if (funct3[1:0] == 2'b00)
                    o_memAccess = DataAccess_Byte;
                else if (funct3[1:0] == 2'b01)
                    o_memAccess = DataAccess_Half;
            end
            {7'b???????, 3'b000, OpCode_OpIMM},   // ADDI
            {7'b???????, 3'b010, OpCode_OpIMM},   // SLTI
            {7'b???????, 3'b011, OpCode_OpIMM},   // SLTIU
            {7'b???????, 3'b100, OpCode_OpIMM},   // XORI
            {7'b???????, 3'b110, OpCode_OpIMM},   // ORI
            {7'b???????, 3'b111, OpCode_OpIMM}:   // ANDI
            begin
                o_operandBSel = OpBSel_Imm;
                o_regWrEnable = 1'b1;
                case (funct3)
                    3'b000:  o_aluControl = AluOp_ADD;
                    3'b010:  o_aluControl = AluOp_SLT;
                    3'b011:  o_aluControl = AluOp_SLTU;
                    3'b100:  o_aluControl = AluOp_XOR;
                    3'b110:  o_aluControl = AluOp_OR;
                    default: o_aluControl = AluOp_AND;
                endcase
            end
            {7'b0000000, 3'b???, OpCode_Op},      // Every funct3 defined here
            {7'b0100000, 3'b000, OpCode_Op},      // SUB
            {7'b0100000, 3'b101, OpCode_Op}:      // SRA
            begin
                o_regWrEnable = 1'b1;
                case (funct3)
                    3'b000:  o_aluControl = i_inst[30] ? AluOp_SUB : AluOp_ADD;
                    3'b001:  o_aluControl = AluOp_SLL;
                    3'b010:  o_aluControl = AluOp_SLT;
                    3'b011:  o_aluControl = AluOp_SLTU;
                    3'b100:  o_aluControl = AluOp_XOR;
                    3'b101:  o_aluControl = i_inst[30] ? AluOp_SRA : AluOp_SRL;
                    3'b110:  o_aluControl = AluOp_OR;
                    default: o_aluControl = AluOp_AND;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/imm_gen.sv ====
module imm_gen
    import rv_pkg::*;
(
    input  Inst i_inst,  // Current instruction
    output Word o_imm    // Sign-extended immediate
);

    Word imm_i;
    Word imm_s;
    Word imm_b;
    Word imm_u;
    Word imm_j;

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};  // Upper twenty bits
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    always_comb
    begin
        case (i_inst[6:0])
            OpCode_LUI,
            OpCode_AUIPC:  o_imm = imm_u;
            OpCode_JAL:    o_imm = imm_j;
            OpCode_Branch: o_imm = imm_b;
            OpCode_Store:  o_imm = imm_s;
            default:       o_imm = imm_i;  // JALR, loads, OP-IMM
        endcase
    end

endmodule

// ==== logic/load_store_unit.sv ====
module load_store_unit
    import rv_pkg::*;
(
    input  Word        i_addr,         // Byte address
    input  DataAccess  i_access,       // Access size
    input  logic       i_unsigned,     // Zero-extend on load
    input  logic       i_wr_enable,    // Store this cycle
    input  Word        i_store_data,   // rs2 value
    input  Word        i_mem_rd_data,  // Whole word from memory
    output logic [3:0] o_byte_enable,  // Lane enables
    output Word        o_mem_wr_data,  // Lane-replicated store data
    output Word        o_load_data     // Extended load result
);

    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    always_comb
    begin
        case (i_access)
            DataAccess_Byte:
            begin
                o_mem_wr_data = {4{i_store_data[7:0]}};
                o_byte_enable = 4'b0001 << i_addr[1:0];
            end
            DataAccess_Half:
            begin
                o_mem_wr_data = {2{i_store_data[15:0]}};
                o_byte_enable = i_addr[1] ? 4'b1100 : 4'b0011;  // Bit 0 ignored
            end
            default:
            begin
                o_mem_wr_data = i_store_data;
                o_byte_enable = 4'b1111;
            end
        endcase
        if (!i_wr_enable)
            o_byte_enable = 4'b0000;
    end

    assign rd_byte = i_mem_rd_data[8*i_addr[1:0] +: 8];
    assign rd_half = i_addr[1] ? i_mem_rd_data[31:16] : i_mem_rd_data[15:0];

    always_comb
    begin
        case (i_access)
            DataAccess_Byte: o_load_data = {{24{rd_byte[7] & ~i_unsigned}}, rd_byte};
            DataAccess_Half: o_load_data = {{16{rd_half[15] & ~i_unsigned}}, rd_half};
            default:         o_load_data = i_mem_rd_data;
        endcase
    end

endmodule

// ==== logic/register_file.sv ====
module register_file
    import rv_pkg::*;
(
    input  logic   i_clock,
    input  RegAddr i_rs1,        // Read port A index
    input  RegAddr i_rs2,        // Read port B index
    input  RegAddr i_rd,         // Write index
    input  logic   i_wr_enable,  // Write strobe
    input  Word    i_wr_data,    // Write value
    output Word    o_rs1_data,
    output Word    o_rs2_data
);

    Word regs [32];

    // x0 is never written, so its slot is masked on read
    assign o_rs1_data = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];

    always_ff @(posedge i_clock)
    begin
        if (i_wr_enable && i_rd != 5'd0)
            regs[i_rd] <= i_wr_data;
    end

endmodule

// ==== logic/rv_core.sv ====
module rv_core
    import rv_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_reset,
    output Word        o_inst_addr,        // Fetch address
    input  Inst        i_inst,             // Fetched word, same cycle
    output Word        o_mem_addr,
    output logic       o_mem_wr_enable,
    output logic       o_mem_rd_enable,
    output logic [3:0] o_mem_byte_enable,
    output Word        o_mem_wr_data,
    input  Word        i_mem_rd_data       // Whole word, same cycle
);

    logic        mem_wr_enable;
    logic        mem_rd_enable;
    DataAccess   mem_access;
    logic        mem_unsigned;
    PcNextSel    pc_next_sel;
    AluOp        alu_control;
    OperandASel  operand_a_sel;
    OperandBSel  operand_b_sel;
    logic        reg_wr_enable;
    RegWrDataSel reg_wr_data_sel;
    logic        is_equal;
    logic        is_less_signed;
    logic        is_less_unsigned;

    datapath_controller u_datapath_controller (
        .i_inst           (i_inst),
        .i_isEqual        (is_equal),
        .i_isLessSigned   (is_less_signed),
        .i_isLessUnsigned (is_less_unsigned),
        .o_memWrEnable    (mem_wr_enable),
        .o_memRdEnable    (mem_rd_enable),
        .o_memAccess      (mem_access),
        .o_memUnsigned    (mem_unsigned),
        .o_pcNextSel      (pc_next_sel),
        .o_aluControl     (alu_control),
        .o_operandASel    (operand_a_sel),
        .o_operandBSel    (operand_b_sel),
        .o_regWrEnable    (reg_wr_enable),
        .o_regWrDataSel   (reg_wr_data_sel)
    );

    // No memory traffic while in reset
    assign o_mem_wr_enable = mem_wr_enable & ~i_reset;
    assign o_mem_rd_enable = mem_rd_enable & ~i_reset;

    datapath u_datapath (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_inst            (i_inst),
        .i_mem_wr_enable   (o_mem_wr_enable),  // Keeps lanes off in reset
        .i_mem_access      (mem_access),
        .i_mem_unsigned    (mem_unsigned),
        .i_pc_next_sel     (pc_next_sel),
        .i_alu_control     (alu_control),
        .i_operand_a_sel   (operand_a_sel),
        .i_operand_b_sel   (operand_b_sel),
        .i_reg_wr_enable   (reg_wr_enable),
        .i_reg_wr_data_sel (reg_wr_data_sel),
        .i_mem_rd_data     (i_mem_rd_data),
        .o_pc              (o_inst_addr),
        .o_isEqual         (is_equal),
        .o_isLessSigned    (is_less_signed),
        .o_isLessUnsigned  (is_less_unsigned),
        .o_mem_addr        (o_mem_addr),
        .o_mem_wr_data     (o_mem_wr_data),
        .o_byte_enable     (o_mem_byte_enable)
    );

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] Inst;     // Raw instruction word
    typedef logic [31:0] Word;     // Data or address value
    typedef logic [4:0]  RegAddr;  // Register index

    localparam Word RESET_PC = 32'h0000_0000;  // First fetch address

    typedef enum logic [6:0] {
        OpCode_LUI    = 7'b0110111,
        OpCode_AUIPC  = 7'b0010111,
        OpCode_JAL    = 7'b1101111,
        OpCode_JALR   = 7'b1100111,
        OpCode_Branch = 7'b1100011,
        OpCode_Load   = 7'b0000011,
        OpCode_Store  = 7'b0100011,
        OpCode_OpIMM  = 7'b0010011,
        OpCode_Op     = 7'b0110011
    } OpCode;

    typedef enum logic [3:0] {
        AluOp_ADD,
        AluOp_SUB,
        AluOp_SLL,
        AluOp_SLT,
        AluOp_SLTU,
        AluOp_XOR,
        AluOp_SRL,
        AluOp_SRA,
        AluOp_OR,
        AluOp_AND,
        AluOp_Unknown  // Treated as ADD by the ALU
    } AluOp;

    typedef enum logic [1:0] {
        DataAccess_Byte = 2'b00,
        DataAccess_Half = 2'b01,
        DataAccess_Word = 2'b10
    } DataAccess;

    typedef enum logic [1:0] {
        OpASel_Reg  = 2'b00,  // Register rs1
        OpASel_Pc   = 2'b01,  // Current PC
        OpASel_Zero = 2'b10   // Constant zero
    } OperandASel;

    typedef enum logic [1:0] {
        OpBSel_Reg  = 2'b00,  // Register rs2
        OpBSel_Imm  = 2'b01,  // Decoded immediate
        OpBSel_Four = 2'b10   // Constant four
    } OperandBSel;

    typedef enum logic [1:0] {
        WrSel_Alu = 2'b00,  // ALU result
        WrSel_Mem = 2'b01,  // Extended load data
        WrSel_Pc4 = 2'b10   // Link address
    } RegWrDataSel;

    typedef enum logic [1:0] {
        PcSel_Plus4    = 2'b00,  // Sequential
        PcSel_Offset   = 2'b01,  // PC relative
        PcSel_Indirect = 2'b11   // rs1 relative
    } PcNextSel;

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module rv_core_tb -o rv_core_sim

output=$(./obj_dir/rv_core_sim +verilator+error+limit+1000) || true
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
